//--- list.f
hw/aluOpPkg.sv
hw/aluCyclePkg.sv
hw/intArith.sv
hw/intSqrt.sv
hw/intDivider.sv
hw/aluControl.sv
hw/alu.sv
bench/aluTb.sv

//--- run.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f list.f \
        --top-module aluTb -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/ValuTb > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -qx "all tests passed" sim.log; then
    exit 0
fi

echo "Pass message not found in sim.log"
exit 1

//--- bench/aluTb.sv
`timescale 1ns/1ps

module aluTb;

    localparam int singleOps = 900;
    localparam int sqrtOps = 32;
    localparam int divOps = 64;
    // Rough cycle budget including reset
    localparam int plannedCycles = 10 + singleOps * 2 + sqrtOps * 18 + divOps * 34;

    localparam aluOpPkg::funcCode_t singleCodes [19] = '{
        aluOpPkg::opAdd, aluOpPkg::opSub, aluOpPkg::opMul, aluOpPkg::opSlaArith,
        aluOpPkg::opSraArith, aluOpPkg::opEq, aluOpPkg::opNe, aluOpPkg::opGt,
        aluOpPkg::opLt, aluOpPkg::opGtU, aluOpPkg::opLtU, aluOpPkg::opNot,
        aluOpPkg::opAnd, aluOpPkg::opOr, aluOpPkg::opXor, aluOpPkg::opXnor,
        aluOpPkg::opSll, aluOpPkg::opSrl, aluOpPkg::opAdd
    };
    localparam aluOpPkg::word_t corners [5] = '{
        32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF
    };
    localparam aluOpPkg::word_t rootInputs [10] = '{
        32'd0, 32'd1, 32'd4, 32'd9, 32'd15, 32'd144, 32'd1000000,
        32'hFFFE_0001, 32'h4000_0000, 32'hFFFF_FFFF
    };
    localparam aluOpPkg::word_t dividends [10] = '{
        32'd100, -32'sd100, 32'd100, -32'sd100, 32'd7,
        32'd12345, -32'sd5, 32'h8000_0000, 32'h8000_0000, 32'h8000_0000
    };
    localparam aluOpPkg::word_t divisors [10] = '{
        32'd7, 32'd7, -32'sd7, -32'sd7, 32'd100,
        32'd0, 32'd0, 32'hFFFF_FFFF, 32'd1, 32'h8000_0000
    };

    logic                Clock;
    logic                rstN;
    logic                start;
    aluOpPkg::funcCode_t funcCode;
    aluOpPkg::word_t     operandA;
    aluOpPkg::word_t     operandB;
    logic                done;
    aluOpPkg::word_t     result;
    logic [31:0]         lfsrState;
    int                  errorCount;
    int                  checkCount;

    alu u_dut (
        .Clock    (Clock),
        .rstN     (rstN),
        .start    (start),
        .funcCode (funcCode),
        .operandA (operandA),
        .operandB (operandB),
        .done     (done),
        .result   (result)
    );

    always #2 Clock = ~Clock;

    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit of the word
    task automatic drawWord(output aluOpPkg::word_t w);
        int i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            lfsrState = galoisStep(lfsrState);
            w = {w[30:0], lfsrState[0]};
        end
    endtask

    function automatic logic [15:0] floorSqrt(input logic [31:0] v);
        logic [15:0] root;
        logic [15:0] trialRoot;
        int          i;
        root = '0;
        for (i = 15; i >= 0; i--) begin
            trialRoot = root | (16'd1 << i);
            if ({16'b0, trialRoot} * {16'b0, trialRoot} <= v) begin
                root = trialRoot;
            end
        end
        return root;
    endfunction

    function automatic aluOpPkg::word_t modelResult(input aluOpPkg::funcCode_t code,
                                                    input aluOpPkg::word_t a,
                                                    input aluOpPkg::word_t b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        logic [4:0]         sh;
        logic               overflow;
        sa = a;
        sb = b;
        sh = b[4:0];
        overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        // Truncating quotient and remainder where both are defined
        if (b != 0 && !overflow) begin
            sq = sa / sb;
            sr = sa % sb;
        end else begin
            sq = '0;
            sr = '0;
        end
        case (code)
            aluOpPkg::opAdd:      return a + b;
            aluOpPkg::opSub:      return a - b;
            aluOpPkg::opMul:      return a * b;
            aluOpPkg::opSqrt:     return {16'b0, floorSqrt(a)};
            aluOpPkg::opDiv:      return (b == 0) ? 32'hFFFF_FFFF : (overflow ? a : sq);
            aluOpPkg::opMod:      return (b == 0) ? a : (overflow ? 32'd0 : sr);
            aluOpPkg::opSlaArith: return a << sh;
            aluOpPkg::opSraArith: return sa >>> sh;
            aluOpPkg::opEq:       return (a == b) ? 32'd1 : 32'd0;
            aluOpPkg::opNe:       return (a != b) ? 32'd1 : 32'd0;
            aluOpPkg::opGt:       return (sa > sb) ? 32'd1 : 32'd0;
            aluOpPkg::opLt:       return (sa < sb) ? 32'd1 : 32'd0;
            aluOpPkg::opGtU:      return (a > b) ? 32'd1 : 32'd0;
            aluOpPkg::opLtU:      return (a < b) ? 32'd1 : 32'd0;
            aluOpPkg::opNot:      return ~a;
            aluOpPkg::opAnd:      return a & b;
            aluOpPkg::opOr:       return a | b;
            aluOpPkg::opXor:      return a ^ b;
            aluOpPkg::opXnor:     return ~(a ^ b);
            aluOpPkg::opSll:      return a << sh;
            aluOpPkg::opSrl:      return a >> sh;
            default:              return 32'd0;
        endcase
    endfunction

    // Edges from acceptance until done is high again
    function automatic int latencyOf(input aluOpPkg::funcCode_t code);
        if (code == aluOpPkg::opSqrt) begin
            return 17;
        end
        if (code == aluOpPkg::opDiv || code == aluOpPkg::opMod) begin
            return 33;
        end
        return 1;
    endfunction

    task automatic checkWord(input string name, input aluOpPkg::word_t expected,
                             input aluOpPkg::word_t actual);
        checkCount++;
        assert (actual === expected) else begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkCycles(input string name, input int expected, input int actual);
        checkCount++;
        assert (actual == expected) else begin
            $display("Mismatch %s latency: expected %0d, actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    // Starts and ends on a falling edge
    task automatic pulseStart(input aluOpPkg::funcCode_t code, input aluOpPkg::word_t a,
                              input aluOpPkg::word_t b);
        start = 1'b1;
        funcCode = code;
        operandA = a;
        operandB = b;
        @(negedge Clock);
        start = 1'b0;
    endtask

    task automatic awaitDone(input string name, output int cycles);
        cycles = 0;
        while (done !== 1'b1 && cycles < 100) begin
            @(negedge Clock);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("Error: %s, done did not rise within 100 cycles", name);
            errorCount++;
        end
    endtask

    task automatic runOp(input aluOpPkg::funcCode_t code, input aluOpPkg::word_t a,
                         input aluOpPkg::word_t b);
        string name;
        int    cycles;
        name = $sformatf("code %b a=%h b=%h", code, a, b);
        pulseStart(code, a, b);
        checkCount++;
        assert (done === 1'b0) else begin
            $display("Error: %s, done did not fall after start", name);
            errorCount++;
        end
        awaitDone(name, cycles);
        checkCycles(name, latencyOf(code), cycles);
        checkWord(name, modelResult(code, a, b), result);
    endtask

    task automatic resetState();
        checkWord("reset done", 32'd1, {31'b0, done});
        checkWord("reset result", 32'd0, result);
    endtask

    task automatic singleCycleOps();
        aluOpPkg::word_t a;
        aluOpPkg::word_t b;
        int              i;
        foreach (singleCodes[c]) begin
            foreach (corners[x]) begin
                runOp(singleCodes[c], corners[x], corners[(x + 2) % 5]);
            end
        end
        for (i = 0; i < 40; i++) begin
            drawWord(a);
            drawWord(b);
            foreach (singleCodes[c]) begin
                runOp(singleCodes[c], a, b);
            end
        end
    endtask

    task automatic shiftCompare();
        runOp(aluOpPkg::opSll, 32'h0000_00F1, 32'd33);
        runOp(aluOpPkg::opSrl, 32'hF000_0000, 32'hFFFF_FFE4);
        runOp(aluOpPkg::opSlaArith, 32'hC000_0003, 32'd63);
        runOp(aluOpPkg::opSraArith, 32'h8000_0010, 32'd35);
        // Top bit set flips signed against unsigned order
        runOp(aluOpPkg::opGt, 32'h8000_0000, 32'd1);
        runOp(aluOpPkg::opGtU, 32'h8000_0000, 32'd1);
        runOp(aluOpPkg::opLt, 32'h8000_0000, 32'd1);
        runOp(aluOpPkg::opLtU, 32'h8000_0000, 32'd1);
        runOp(aluOpPkg::opGt, 32'd1, 32'hFFFF_FFFF);
        runOp(aluOpPkg::opLtU, 32'd1, 32'hFFFF_FFFF);
    endtask

    task automatic squareRoots();
        aluOpPkg::word_t a;
        int              i;
        foreach (rootInputs[x]) begin
            runOp(aluOpPkg::opSqrt, rootInputs[x], 32'd0);
        end
        for (i = 0; i < 20; i++) begin
            drawWord(a);
            runOp(aluOpPkg::opSqrt, a, 32'd0);
        end
    endtask

    task automatic divisions();
        aluOpPkg::word_t a;
        aluOpPkg::word_t b;
        int              i;
        foreach (dividends[x]) begin
            runOp(aluOpPkg::opDiv, dividends[x], divisors[x]);
            runOp(aluOpPkg::opMod, dividends[x], divisors[x]);
        end
        for (i = 0; i < 20; i++) begin
            drawWord(a);
            drawWord(b);
            // Spread divisor sizes
            b = $signed(b) >>> b[4:0];
            runOp(aluOpPkg::opDiv, a, b);
            runOp(aluOpPkg::opMod, a, b);
        end
    endtask

    task automatic ignoredStart();
        int cycles;
        pulseStart(aluOpPkg::opDiv, 32'hFFFF_0000, 32'd3);
        repeat (4) @(negedge Clock);
        pulseStart(aluOpPkg::opAdd, 32'd5, 32'd6);
        awaitDone("start during divide", cycles);
        checkCycles("start during divide", 33, cycles + 5);
        checkWord("start during divide", modelResult(aluOpPkg::opDiv, 32'hFFFF_0000, 32'd3),
                  result);
        @(negedge Clock);
        checkWord("no second launch", 32'd1, {31'b0, done});
        runOp(6'b100000, 32'h3F80_0000, 32'h4000_0000);
        runOp(6'b010101, 32'h1234_5678, 32'h0000_00FF);
    endtask

    initial begin
        Clock = 1'b0;
        rstN = 1'b0;
        start = 1'b0;
        funcCode = '0;
        operandA = '0;
        operandB = '0;
        lfsrState = 32'd98;
        errorCount = 0;
        checkCount = 0;
        repeat (10) @(negedge Clock);
        rstN = 1'b1;
        @(negedge Clock);
        resetState();
        singleCycleOps();
        shiftCompare();
        squareRoots();
        divisions();
        ignoredStart();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(plannedCycles * 40 * 4);
        $display("Watchdog expired before the tests completed");
        $display("tests failed");
        $finish;
    end

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                Clock,
    input  logic                rstN,
    input  logic                start,
    input  aluOpPkg::funcCode_t funcCode,
    input  aluOpPkg::word_t     operandA,
    input  aluOpPkg::word_t     operandB,
    output logic                done,
    output aluOpPkg::word_t     result
);

    aluOpPkg::word_t arithResult;
    aluOpPkg::half_t sqrtRoot;
    aluOpPkg::word_t quotient;
    aluOpPkg::word_t remainder;
    logic            sqrtStart;
    logic            sqrtDone;
    logic            divStart;
    logic            divDone;

    intArith u_intArith (
        .funcCode    (funcCode),
        .operandA    (operandA),
        .operandB    (operandB),
        .arithResult (arithResult)
    );

    aluControl u_aluControl (
        .Clock       (Clock),
        .rstN        (rstN),
        .start       (start),
        .funcCode    (funcCode),
        .arithResult (arithResult),
        .sqrtDone    (sqrtDone),
        .sqrtRoot    (sqrtRoot),
        .divDone     (divDone),
        .quotient    (quotient),
        .remainder   (remainder),
        .sqrtStart   (sqrtStart),
        .divStart    (divStart),
        .done        (done),
        .result      (result)
    );

    intSqrt u_intSqrt (
        .Clock     (Clock),
        .rstN      (rstN),
        .sqrtStart (sqrtStart),
        .radicand  (operandA),
        .sqrtDone  (sqrtDone),
        .sqrtRoot  (sqrtRoot)
    );

    intDivider u_intDivider (
        .Clock     (Clock),
        .rstN      (rstN),
        .divStart  (divStart),
        .dividend  (operandA),
        .divisor   (operandB),
        .divDone   (divDone),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

//--- hw/aluControl.sv
`timescale 1ns/1ps

module aluControl (
    input  logic                Clock,
    input  logic                rstN,
    input  logic                start,
    input  aluOpPkg::funcCode_t funcCode,
    input  aluOpPkg::word_t     arithResult,
    input  logic                sqrtDone,
    input  aluOpPkg::half_t     sqrtRoot,
    input  logic                divDone,
    input  aluOpPkg::word_t     quotient,
    input  aluOpPkg::word_t     remainder,
    output logic                sqrtStart,
    output logic                divStart,
    output logic                done,
    output aluOpPkg::word_t     result
);

    aluCyclePkg::ctrlState_t state;
    logic                    accept;
    logic                    isSqrt;
    logic                    isDiv;
    logic                    sqrtOp;
    logic                    modOp;

    assign isSqrt = (funcCode == aluOpPkg::opSqrt);
    assign isDiv  = (funcCode == aluOpPkg::opDiv) || (funcCode == aluOpPkg::opMod);

    // Start only counts while idle
    assign accept = (state == aluCyclePkg::idle) && start;

    // Launch strobes, units load on the acceptance edge
    assign sqrtStart = accept && isSqrt;
    assign divStart  = accept && isDiv;

    assign done = (state == aluCyclePkg::idle);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state  <= aluCyclePkg::idle;
            result <= '0;
            sqrtOp <= 1'b0;
            modOp  <= 1'b0;
        end else begin
            case (state)
                aluCyclePkg::idle: begin
                    if (start) begin
                        sqrtOp <= isSqrt;
                        modOp  <= (funcCode == aluOpPkg::opMod);
                        if (isSqrt || isDiv) begin
                            state <= aluCyclePkg::waitUnit;
                        end else begin
                            result <= arithResult;
                            state  <= aluCyclePkg::finish;
                        end
                    end
                end
                aluCyclePkg::waitUnit: begin
                    if (sqrtOp && sqrtDone) begin
                        result <= {16'b0, sqrtRoot};
                        state  <= aluCyclePkg::idle;
                    end else if (!sqrtOp && divDone) begin
                        result <= modOp ? remainder : quotient;
                        state  <= aluCyclePkg::idle;
                    end
                end
                aluCyclePkg::finish: begin
                    state <= aluCyclePkg::idle;
                end
                default: begin
                    state <= aluCyclePkg::idle;
                end
            endcase
        end
    end

endmodule

//--- hw/intDivider.sv
`timescale 1ns/1ps

module intDivider (
    input  logic            Clock,
    input  logic            rstN,
    input  logic            divStart,
    input  aluOpPkg::word_t dividend,
    input  aluOpPkg::word_t divisor,
    output logic            divDone,
    output aluOpPkg::word_t quotient,
    output aluOpPkg::word_t remainder
);

    aluOpPkg::word_t         remReg;
    aluOpPkg::word_t         quoReg;
    aluOpPkg::word_t         divisorMag;
    logic                    negQuot;
    logic                    negRem;
    logic [32:0]             trial;
    aluCyclePkg::stepCount_t stepsLeft;
    logic                    busy;

    assign busy = (stepsLeft != '0);

    // Next dividend bit enters the partial remainder
    assign trial = {remReg, quoReg[31]} - {1'b0, divisorMag};

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            stepsLeft <= '0;
            divDone   <= 1'b0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                stepsLeft <= aluCyclePkg::divSteps;
            end else if (busy) begin
                stepsLeft <= stepsLeft - 1'b1;
                if (stepsLeft == 6'd1) begin
                    divDone <= 1'b1;
                end
            end
        end
    end

    // Datapath, quoReg holds the dividend magnitude and fills with quotient bits
    always_ff @(posedge Clock) begin
        if (divStart) begin
            remReg     <= '0;
            quoReg     <= dividend[31] ? -dividend : dividend;
            divisorMag <= divisor[31] ? -divisor : divisor;
            negQuot    <= dividend[31] ^ divisor[31];
            negRem     <= dividend[31];
        end else if (busy) begin
            if (!trial[32]) begin
                remReg <= trial[31:0];
            end else begin
                // Restore
                remReg <= {remReg[30:0], quoReg[31]};
            end
            quoReg <= {quoReg[30:0], ~trial[32]};
        end
    end

    // Sign restore
    // Most negative by minus one wraps back to itself here
    always_comb begin
        if (divisorMag == '0) begin
            quotient = '1;
        end else if (negQuot) begin
            quotient = -quoReg;
        end else begin
            quotient = quoReg;
        end
    end

    // Remainder follows the dividend, also on divide by zero
    assign remainder = negRem ? -remReg : remReg;

endmodule

//--- hw/intSqrt.sv
`timescale 1ns/1ps

module intSqrt (
    input  logic             Clock,
    input  logic             rstN,
    input  logic             sqrtStart,
    input  aluOpPkg::word_t  radicand,
    output logic             sqrtDone,
    output aluOpPkg::half_t  sqrtRoot
);

    aluOpPkg::word_t         radShift;
    logic signed [19:0]      partRem;
    logic signed [19:0]      nextRem;
    aluCyclePkg::stepCount_t stepsLeft;
    logic                    busy;

    assign busy = (stepsLeft != '0);

    // Non-restoring step, sign of the partial remainder picks add or subtract
    always_comb begin
        if (!partRem[19]) begin
            nextRem = {partRem[17:0], radShift[31:30]} - {2'b00, sqrtRoot, 2'b01};
        end else begin
            nextRem = {partRem[17:0], radShift[31:30]} + {2'b00, sqrtRoot, 2'b11};
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            stepsLeft <= '0;
            sqrtDone  <= 1'b0;
        end else begin
            sqrtDone <= 1'b0;
            if (sqrtStart) begin
                stepsLeft <= aluCyclePkg::sqrtSteps;
            end else if (busy) begin
                stepsLeft <= stepsLeft - 1'b1;
                if (stepsLeft == 6'd1) begin
                    sqrtDone <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge Clock) begin
        if (sqrtStart) begin
            radShift <= radicand;
            partRem  <= '0;
            sqrtRoot <= '0;
        end else if (busy) begin
            radShift <= {radShift[29:0], 2'b00};
            partRem  <= nextRem;
            // New root bit is set when the remainder stays non-negative
            sqrtRoot <= {sqrtRoot[14:0], ~nextRem[19]};
        end
    end

endmodule

//--- hw/intArith.sv
`timescale 1ns/1ps

module intArith (
    input  aluOpPkg::funcCode_t funcCode,
    input  aluOpPkg::word_t     operandA,
    input  aluOpPkg::word_t     operandB,
    output aluOpPkg::word_t     arithResult
);

    aluOpPkg::shamt_t shiftAmount;
    logic             signedGt;
    logic             signedLt;

    // Only the low five bits of B count as shift distance
    assign shiftAmount = operandB[4:0];

    assign signedGt = $signed(operandA) > $signed(operandB);
    assign signedLt = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (funcCode)
            aluOpPkg::opAdd: begin
                arithResult = operandA + operandB;
            end
            aluOpPkg::opSub: begin
                arithResult = operandA - operandB;
            end
            aluOpPkg::opMul: begin
                // Low word is the same for signed and unsigned
                arithResult = operandA * operandB;
            end
            aluOpPkg::opSlaArith: begin
                arithResult = $signed(operandA) <<< shiftAmount;
            end
            aluOpPkg::opSraArith: begin
                arithResult = $signed(operandA) >>> shiftAmount;
            end
            aluOpPkg::opEq: begin
                arithResult = {31'b0, operandA == operandB};
            end
            aluOpPkg::opNe: begin
                arithResult = {31'b0, operandA != operandB};
            end
            aluOpPkg::opGt: begin
                arithResult = {31'b0, signedGt};
            end
            aluOpPkg::opLt: begin
                arithResult = {31'b0, signedLt};
            end
            aluOpPkg::opGtU: begin
                arithResult = {31'b0, operandA > operandB};
            end
            aluOpPkg::opLtU: begin
                arithResult = {31'b0, operandA < operandB};
            end
            aluOpPkg::opNot: begin
                arithResult = ~operandA;
            end
            aluOpPkg::opAnd: begin
                arithResult = operandA & operandB;
            end
            aluOpPkg::opOr: begin
                arithResult = operandA | operandB;
            end
            aluOpPkg::opXor: begin
                arithResult = operandA ^ operandB;
            end
            aluOpPkg::opXnor: begin
                arithResult = operandA ~^ operandB;
            end
            aluOpPkg::opSll: begin
                arithResult = operandA << shiftAmount;
            end
            aluOpPkg::opSrl: begin
                arithResult = operandA >> shiftAmount;
            end
            default: begin
                // Float codes, conversions and unassigned codes
                arithResult = '0;
            end
        endcase
    end

endmodule

//--- hw/aluCyclePkg.sv
package aluCyclePkg;

    typedef logic [5:0] stepCount_t;

    // One root bit per iteration
    localparam stepCount_t sqrtSteps = 6'd16;

    // One quotient bit per iteration
    localparam stepCount_t divSteps = 6'd32;

    typedef enum logic [1:0] {
        idle,
        waitUnit,
        finish
    } ctrlState_t;

endpackage

//--- hw/aluOpPkg.sv
package aluOpPkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  funcCode_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] half_t;

    // Integer group
    localparam funcCode_t opAdd      = 6'b000000;
    localparam funcCode_t opSub      = 6'b000001;
    localparam funcCode_t opMul      = 6'b000010;
    localparam funcCode_t opSqrt     = 6'b000011;
    localparam funcCode_t opDiv      = 6'b000100;
    localparam funcCode_t opMod      = 6'b000101;
    localparam funcCode_t opSlaArith = 6'b000110;
    localparam funcCode_t opSraArith = 6'b000111;
    localparam funcCode_t opEq       = 6'b001000;
    localparam funcCode_t opNe       = 6'b001001;
    localparam funcCode_t opGt       = 6'b001010;
    localparam funcCode_t opLt       = 6'b001011;
    localparam funcCode_t opGtU      = 6'b001100;
    localparam funcCode_t opLtU      = 6'b001101;

    // Logic group, 010101 is unassigned
    localparam funcCode_t opNot      = 6'b010000;
    localparam funcCode_t opAnd      = 6'b010001;
    localparam funcCode_t opOr       = 6'b010010;
    localparam funcCode_t opXor      = 6'b010011;
    localparam funcCode_t opXnor     = 6'b010100;
    localparam funcCode_t opSll      = 6'b010110;
    localparam funcCode_t opSrl      = 6'b010111;

endpackage
